// File: hdl/stats_params.svh
`ifndef STATS_PARAMS_SVH
`define STATS_PARAMS_SVH

// ingress stream beat
`define BEAT_BYTES      64
`define EMPTY_W         6
`define LEN_W           16

// channel fifo occupancy for a depth of 512
`define FILL_W          10
`define FILL_WINDOW     8

`define CNT_W           32

// status bus address split
`define STATUS_AW       30
`define STAT_AWIDTH     4
`define TOP_REG         4'd2

// register indices
`define REG_CTRL        8'd0
`define REG_PKT_CNT     8'd1
`define REG_BYTE_CNT    8'd2
`define REG_MAX_FILL    8'd3

// control register bits
`define CTRL_FREEZE_BIT 0
`define CTRL_CLEAR_BIT  1

`endif

// File: hdl/stats_pkg.sv
`include "stats_params.svh"

package stats_pkg;

   // which collector produced the message
   typedef enum logic {
      MSG_INC = 1'b0,   // one finished packet
      MSG_MAX = 1'b1    // peak fill of one window
   } msg_kind_e;

   typedef struct packed {
      logic [`LEN_W-1:0] len;   // packet length in bytes
   } inc_rec_t;

   typedef struct packed {
      logic [`LEN_W-`FILL_W-1:0] pad;
      logic [`FILL_W-1:0]        peak;   // highest level in window
   } max_rec_t;

   // one 16-bit word read per kind
   typedef union packed {
      inc_rec_t inc_rec;
      max_rec_t max_rec;
   } msg_body_u;

   typedef struct packed {
      msg_kind_e kind;
      msg_body_u body;
   } stats_msg_t;

   typedef logic [7:0] reg_idx_t;

endpackage

// File: hdl/pkt_counter.sv
`timescale 1ns/1ns
`include "stats_params.svh"

module pkt_counter (
   input  logic                  clk_status,
   input  logic                  rst_i,
   input  logic                  in_valid_i,
   input  logic                  in_sop_i,
   input  logic                  in_eop_i,
   input  logic [`EMPTY_W-1:0]   in_empty_i,
   output logic                  msg_valid_o,
   output stats_pkg::stats_msg_t msg_o
);
   import stats_pkg::*;

   logic [`LEN_W-1:0] run_len;     // bytes so far in current packet
   logic [`LEN_W-1:0] beat_bytes;
   logic [`LEN_W-1:0] base_len;
   logic [`LEN_W-1:0] sum_len;
   logic [`LEN_W-1:0] done_len;    // length of last finished packet

   always_comb begin
      beat_bytes = `LEN_W'(`BEAT_BYTES);
      if (in_eop_i) begin
         beat_bytes = `LEN_W'(`BEAT_BYTES) - `LEN_W'(in_empty_i);   // partial last beat
      end
      base_len = in_sop_i ? '0 : run_len;   // sop restarts the sum
      sum_len  = base_len + beat_bytes;
   end

   always_ff @(posedge clk_status) begin
      if (rst_i) begin
         run_len     <= '0;
         msg_valid_o <= 1'b0;
      end else begin
         msg_valid_o <= in_valid_i & in_eop_i;
         if (in_valid_i) begin
            run_len <= in_eop_i ? '0 : sum_len;
         end
      end
   end

   always_ff @(posedge clk_status) begin
      if (in_valid_i && in_eop_i) begin
         done_len <= sum_len;
      end
   end

   always_comb begin
      msg_o                  = '0;
      msg_o.kind             = MSG_INC;
      msg_o.body.inc_rec.len = done_len;
   end

endmodule

// File: hdl/fill_tracker.sv
`timescale 1ns/1ns
`include "stats_params.svh"

module fill_tracker (
   input  logic                  clk_status,
   input  logic                  rst_i,
   input  logic [`FILL_W-1:0]    fill_level_i,
   output logic                  msg_valid_o,
   output stats_pkg::stats_msg_t msg_o
);
   import stats_pkg::*;

   localparam int WIN_W = $clog2(`FILL_WINDOW);

   logic [WIN_W-1:0]   win_cnt;     // position inside current window
   logic               win_last;
   logic [`FILL_W-1:0] peak;
   logic [`FILL_W-1:0] peak_next;
   logic [`FILL_W-1:0] rep_peak;    // peak of the window just closed

   assign win_last  = (win_cnt == WIN_W'(`FILL_WINDOW - 1));
   assign peak_next = (fill_level_i > peak) ? fill_level_i : peak;

   always_ff @(posedge clk_status) begin
      if (rst_i) begin
         win_cnt     <= '0;
         peak        <= '0;
         msg_valid_o <= 1'b0;
      end else begin
         msg_valid_o <= win_last;
         if (win_last) begin
            win_cnt <= '0;
            peak    <= '0;   // new window starts empty
         end else begin
            win_cnt <= win_cnt + 1'b1;
            peak    <= peak_next;
         end
      end
   end

   always_ff @(posedge clk_status) begin
      if (win_last) begin
         rep_peak <= peak_next;   // includes level of last cycle
      end
   end

   always_comb begin
      msg_o                   = '0;
      msg_o.kind              = MSG_MAX;
      msg_o.body.max_rec.pad  = '0;
      msg_o.body.max_rec.peak = rep_peak;
   end

endmodule

// File: hdl/stats_regfile.sv
`timescale 1ns/1ns
`include "stats_params.svh"

module stats_regfile (
   input  logic                  clk_status,
   input  logic                  rst_i,
   input  logic                  pkt_msg_valid_i,
   input  stats_pkg::stats_msg_t pkt_msg_i,
   input  logic                  fill_msg_valid_i,
   input  stats_pkg::stats_msg_t fill_msg_i,
   input  logic                  freeze_i,
   input  logic                  clear_i,
   input  stats_pkg::reg_idx_t   rd_idx_i,
   output logic [`CNT_W-1:0]     rd_data_o
);
   import stats_pkg::*;

   logic [`CNT_W-1:0]  pkt_cnt;
   logic [`CNT_W-1:0]  byte_cnt;
   logic [`FILL_W-1:0] max_fill;

   msg_body_u          pkt_body;
   msg_body_u          fill_body;
   logic               inc_hit;
   logic               max_hit;
   logic [`LEN_W-1:0]  inc_len;
   logic [`FILL_W-1:0] max_peak;

   // both sources hit disjoint registers, so no arbitration
   always_comb begin
      pkt_body  = pkt_msg_i.body;
      fill_body = fill_msg_i.body;
      inc_hit   = pkt_msg_valid_i && (pkt_msg_i.kind == MSG_INC);
      max_hit   = fill_msg_valid_i && (fill_msg_i.kind == MSG_MAX);
      inc_len   = pkt_body.inc_rec.len;      // body as increment
      max_peak  = fill_body.max_rec.peak;    // body as peak report
   end

   always_ff @(posedge clk_status) begin
      if (rst_i || clear_i) begin   // clear beats freeze
         pkt_cnt  <= '0;
         byte_cnt <= '0;
         max_fill <= '0;
      end else if (!freeze_i) begin
         if (inc_hit) begin
            pkt_cnt  <= pkt_cnt + 1'b1;
            byte_cnt <= byte_cnt + `CNT_W'(inc_len);
         end
         if (max_hit && (max_peak > max_fill)) begin
            max_fill <= max_peak;   // only ever grows
         end
      end
   end

   always_comb begin
      case (rd_idx_i)
         `REG_PKT_CNT:  rd_data_o = pkt_cnt;
         `REG_BYTE_CNT: rd_data_o = byte_cnt;
         `REG_MAX_FILL: rd_data_o = `CNT_W'(max_fill);
         default:       rd_data_o = '0;   // unmapped index
      endcase
   end

endmodule

// File: hdl/status_csr.sv
`timescale 1ns/1ns
`include "stats_params.svh"

module status_csr (
   input  logic                    clk_status,
   input  logic                    rst_i,
   input  logic [`STATUS_AW-1:0]   status_addr_i,
   input  logic                    status_read_i,
   input  logic                    status_write_i,
   input  logic [`CNT_W-1:0]       status_writedata_i,
   input  logic [`CNT_W-1:0]       stats_rd_data_i,
   output stats_pkg::reg_idx_t     stats_rd_idx_o,
   output logic                    freeze_o,
   output logic                    clear_o,
   output logic [`CNT_W-1:0]       status_readdata_o,
   output logic                    status_readdata_valid_o
);
   import stats_pkg::*;

   reg_idx_t                addr_idx_r;
   logic [`STAT_AWIDTH-1:0] addr_sel_r;    // top-level block select
   logic                    read_r;
   logic                    write_r;
   logic [`CNT_W-1:0]       writedata_r;
   logic [`CNT_W-1:0]       ctrl_reg;
   logic                    sel_hit;

   assign sel_hit        = (addr_sel_r == `TOP_REG);
   assign stats_rd_idx_o = addr_idx_r;
   assign freeze_o       = ctrl_reg[`CTRL_FREEZE_BIT];
   assign clear_o        = ctrl_reg[`CTRL_CLEAR_BIT];

   // first stage captures the bus
   always_ff @(posedge clk_status) begin
      addr_idx_r  <= status_addr_i[7:0];
      addr_sel_r  <= status_addr_i[`STATUS_AW-1 -: `STAT_AWIDTH];
      writedata_r <= status_writedata_i;
   end

   always_ff @(posedge clk_status) begin
      if (rst_i) begin
         read_r                  <= 1'b0;
         write_r                 <= 1'b0;
         ctrl_reg                <= '0;
         status_readdata_valid_o <= 1'b0;
      end else begin
         read_r                  <= status_read_i;
         write_r                 <= status_write_i;
         status_readdata_valid_o <= read_r & sel_hit;   // one-cycle pulse
         if (write_r && sel_hit) begin
            if (addr_idx_r == `REG_CTRL) begin
               ctrl_reg <= writedata_r;
            end else begin
               ctrl_reg <= '0;   // any other index wipes control
            end
         end
      end
   end

   // second stage returns the read data
   always_ff @(posedge clk_status) begin
      if (read_r && sel_hit) begin
         if (addr_idx_r == `REG_CTRL) begin
            status_readdata_o <= ctrl_reg;
         end else begin
            status_readdata_o <= stats_rd_data_i;
         end
      end
   end

endmodule

// File: hdl/stats_top.sv
`timescale 1ns/1ns
`include "stats_params.svh"

module stats_top (
   input  logic                  clk_status,
   input  logic                  rst_i,
   input  logic                  in_valid_i,
   input  logic                  in_sop_i,
   input  logic                  in_eop_i,
   input  logic [`EMPTY_W-1:0]   in_empty_i,
   input  logic [`FILL_W-1:0]    fill_level_i,
   input  logic [`STATUS_AW-1:0] status_addr_i,
   input  logic                  status_read_i,
   input  logic                  status_write_i,
   input  logic [`CNT_W-1:0]     status_writedata_i,
   output logic [`CNT_W-1:0]     status_readdata_o,
   output logic                  status_readdata_valid_o
);
   import stats_pkg::*;

   stats_msg_t        pkt_msg;
   logic              pkt_msg_valid;
   stats_msg_t        fill_msg;
   logic              fill_msg_valid;
   reg_idx_t          stats_rd_idx;
   logic [`CNT_W-1:0] stats_rd_data;
   logic              freeze;
   logic              clear;

   pkt_counter u_pkt_counter (
      .clk_status  (clk_status),
      .rst_i       (rst_i),
      .in_valid_i  (in_valid_i),
      .in_sop_i    (in_sop_i),
      .in_eop_i    (in_eop_i),
      .in_empty_i  (in_empty_i),
      .msg_valid_o (pkt_msg_valid),
      .msg_o       (pkt_msg)
   );

   fill_tracker u_fill_tracker (
      .clk_status   (clk_status),
      .rst_i        (rst_i),
      .fill_level_i (fill_level_i),
      .msg_valid_o  (fill_msg_valid),
      .msg_o        (fill_msg)
   );

   stats_regfile u_stats_regfile (
      .clk_status       (clk_status),
      .rst_i            (rst_i),
      .pkt_msg_valid_i  (pkt_msg_valid),
      .pkt_msg_i        (pkt_msg),
      .fill_msg_valid_i (fill_msg_valid),
      .fill_msg_i       (fill_msg),
      .freeze_i         (freeze),
      .clear_i          (clear),
      .rd_idx_i         (stats_rd_idx),
      .rd_data_o        (stats_rd_data)   // combinational read
   );

   status_csr u_status_csr (
      .clk_status              (clk_status),
      .rst_i                   (rst_i),
      .status_addr_i           (status_addr_i),
      .status_read_i           (status_read_i),
      .status_write_i          (status_write_i),
      .status_writedata_i      (status_writedata_i),
      .stats_rd_data_i         (stats_rd_data),
      .stats_rd_idx_o          (stats_rd_idx),
      .freeze_o                (freeze),
      .clear_o                 (clear),
      .status_readdata_o       (status_readdata_o),
      .status_readdata_valid_o (status_readdata_valid_o)
   );

endmodule

// File: bench/tb_stats_tasks.svh
task automatic idle_cycles(input int n);   // tasks start and end 1 ns after a rising edge
   repeat (n) begin
      @(posedge clk_status);
      #1;
   end
endtask

task automatic bus_read(input logic [`STAT_AWIDTH-1:0] sel, input logic [7:0] idx,
                        output logic [31:0] data);
   status_addr_i = make_addr(sel, idx);
   status_read_i = 1'b1;
   idle_cycles(1);   // strobe sampled here
   status_read_i = 1'b0;
   if (status_readdata_valid_o) report_error("read valid came one edge after the strobe");
   idle_cycles(1);
   data = '0;
   if (sel == `TOP_REG) begin
      if (!status_readdata_valid_o) report_error("no read valid two edges after the strobe");
      data = status_readdata_o;
      reads_expected++;
   end else if (status_readdata_valid_o) begin
      report_error("read with a foreign select field gave a valid pulse");
   end
   idle_cycles(1);
   if (status_readdata_valid_o) report_error("read valid stayed high for more than one cycle");
endtask

task automatic bus_write(input logic [`STAT_AWIDTH-1:0] sel, input logic [7:0] idx,
                         input logic [31:0] data);
   status_addr_i      = make_addr(sel, idx);
   status_writedata_i = data;
   status_write_i     = 1'b1;
   idle_cycles(1);
   status_write_i = 1'b0;
   idle_cycles(1);   // control register loads here
endtask

task automatic read_expect(input logic [7:0] idx, input logic [31:0] expected,
                           input string name);
   logic [31:0] data;
   bus_read(`TOP_REG, idx, data);
   check_value(name, data, expected);
endtask

task automatic send_packet(input int len);
   int beats;
   beats = (len + `BEAT_BYTES - 1) / `BEAT_BYTES;
   for (int i = 0; i < beats; i++) begin
      in_valid_i = 1'b1;
      in_sop_i   = (i == 0);
      in_eop_i   = (i == beats - 1);
      in_empty_i = (i == beats - 1) ? `EMPTY_W'(beats * `BEAT_BYTES - len) : '0;
      idle_cycles(1);
   end
   in_valid_i = 1'b0;   // overwritten at once by a back to back packet
   in_sop_i   = 1'b0;
   in_eop_i   = 1'b0;
   in_empty_i = '0;
endtask

task automatic send_random_packets(input int n, input bit counted);
   logic [31:0] r;
   int          len;
   for (int i = 0; i < n; i++) begin
      r   = next_rand();
      len = 1 + int'(r % 1500);
      send_packet(len);
      if (counted) begin
         exp_pkt_cnt  = exp_pkt_cnt + 1;
         exp_byte_cnt = exp_byte_cnt + len;
      end
      r = next_rand();
      idle_cycles(int'(r % 3));   // zero gap keeps packets back to back
   end
   idle_cycles(3);   // message and counter latency
endtask

task automatic test_reset_values();
   check_value("status_readdata_valid_o", {31'b0, status_readdata_valid_o}, 32'h0);
   read_expect(`REG_CTRL, 32'h0, "ctrl");
   read_expect(`REG_PKT_CNT, 32'h0, "pkt_cnt");
   read_expect(`REG_BYTE_CNT, 32'h0, "byte_cnt");
   read_expect(`REG_MAX_FILL, 32'h0, "max_fill");
endtask

task automatic test_packet_stats();
   send_random_packets(20, 1'b1);
   read_expect(`REG_PKT_CNT, exp_pkt_cnt, "pkt_cnt");
   read_expect(`REG_BYTE_CNT, exp_byte_cnt, "byte_cnt");
endtask

task automatic test_peak_fill();
   logic [31:0]        r;
   logic [`FILL_W-1:0] peak;
   peak = '0;
   for (int i = 0; i < 40; i++) begin
      r            = next_rand();
      fill_level_i = r[`FILL_W-1:0];
      if (fill_level_i > peak) peak = fill_level_i;
      idle_cycles(1);
   end
   fill_level_i = '0;
   idle_cycles(2 * `FILL_WINDOW + 2);
   read_expect(`REG_MAX_FILL, 32'(peak), "max_fill");
   for (int i = 0; i < 2 * `FILL_WINDOW; i++) begin
      r            = next_rand();
      fill_level_i = (peak == 0) ? '0 : `FILL_W'(r % peak);   // always below the peak
      idle_cycles(1);
   end
   fill_level_i = '0;
   idle_cycles(2 * `FILL_WINDOW + 2);
   read_expect(`REG_MAX_FILL, 32'(peak), "max_fill after lower peak");
endtask

task automatic test_control_reg();
   logic [31:0] data;
   bus_write(`TOP_REG, `REG_CTRL, 32'h5A5A_5A5C);   // freeze and clear bits left low
   read_expect(`REG_CTRL, 32'h5A5A_5A5C, "ctrl");
   bus_write(`TOP_REG, `REG_PKT_CNT, 32'hFFFF_FFFF);
   read_expect(`REG_CTRL, 32'h0, "ctrl after write to pkt_cnt");
   read_expect(`REG_PKT_CNT, exp_pkt_cnt, "pkt_cnt");
   read_expect(`REG_BYTE_CNT, exp_byte_cnt, "byte_cnt");
   bus_write(`TOP_REG, `REG_CTRL, 32'h0000_00F0);
   bus_write(4'd3, `REG_PKT_CNT, 32'h1234_5678);
   bus_write(4'd3, `REG_CTRL, 32'h0000_0003);
   read_expect(`REG_CTRL, 32'h0000_00F0, "ctrl after foreign writes");
   bus_read(4'd3, `REG_CTRL, data);
   bus_write(`TOP_REG, `REG_CTRL, 32'h0);
endtask

task automatic test_freeze_clear();
   bus_write(`TOP_REG, `REG_CTRL, 32'h1 << `CTRL_FREEZE_BIT);
   send_random_packets(3, 1'b0);
   read_expect(`REG_PKT_CNT, exp_pkt_cnt, "pkt_cnt while frozen");
   read_expect(`REG_BYTE_CNT, exp_byte_cnt, "byte_cnt while frozen");
   bus_write(`TOP_REG, `REG_CTRL, 32'h1 << `CTRL_CLEAR_BIT);
   send_random_packets(1, 1'b0);
   read_expect(`REG_PKT_CNT, 32'h0, "pkt_cnt while cleared");
   read_expect(`REG_BYTE_CNT, 32'h0, "byte_cnt while cleared");
   read_expect(`REG_MAX_FILL, 32'h0, "max_fill while cleared");
   bus_write(`TOP_REG, `REG_CTRL, 32'h0);
   exp_pkt_cnt  = '0;
   exp_byte_cnt = '0;
   send_random_packets(4, 1'b1);
   read_expect(`REG_PKT_CNT, exp_pkt_cnt, "pkt_cnt after clear");
   read_expect(`REG_BYTE_CNT, exp_byte_cnt, "byte_cnt after clear");
   read_expect(`REG_MAX_FILL, 32'h0, "max_fill after clear");
endtask

// File: bench/tb_stats_top.sv
`timescale 1ns/1ns
`include "stats_params.svh"

module tb_stats_top;

   localparam int CLK_HALF    = 2;     // 4 ns period
   localparam int T_RESET_CYC = 40;
   localparam int T_PKT_CYC   = 600;   // 20 packets of up to 24 beats plus gaps
   localparam int T_FILL_CYC  = 150;
   localparam int T_CTRL_CYC  = 80;
   localparam int T_FRZ_CYC   = 400;
   localparam int TEST_CYCLES = T_RESET_CYC + T_PKT_CYC + T_FILL_CYC + T_CTRL_CYC + T_FRZ_CYC;

   logic                  clk_status;
   logic                  rst_i;
   logic                  in_valid_i;
   logic                  in_sop_i;
   logic                  in_eop_i;
   logic [`EMPTY_W-1:0]   in_empty_i;
   logic [`FILL_W-1:0]    fill_level_i;
   logic [`STATUS_AW-1:0] status_addr_i;
   logic                  status_read_i;
   logic                  status_write_i;
   logic [`CNT_W-1:0]     status_writedata_i;
   logic [`CNT_W-1:0]     status_readdata_o;
   logic                  status_readdata_valid_o;

   logic [31:0]           rng_state;
   logic [`CNT_W-1:0]     exp_pkt_cnt;     // model of the packet counter
   logic [`CNT_W-1:0]     exp_byte_cnt;
   int                    pulse_cnt;       // read valid cycles seen
   int                    reads_expected;

   stats_top DUT (
      .clk_status              (clk_status),
      .rst_i                   (rst_i),
      .in_valid_i              (in_valid_i),
      .in_sop_i                (in_sop_i),
      .in_eop_i                (in_eop_i),
      .in_empty_i              (in_empty_i),
      .fill_level_i            (fill_level_i),
      .status_addr_i           (status_addr_i),
      .status_read_i           (status_read_i),
      .status_write_i          (status_write_i),
      .status_writedata_i      (status_writedata_i),
      .status_readdata_o       (status_readdata_o),
      .status_readdata_valid_o (status_readdata_valid_o)
   );

   initial begin
      clk_status = 1'b0;
      forever #CLK_HALF clk_status = ~clk_status;
   end

   // counts read valid cycles at mid-cycle
   always @(negedge clk_status) begin
      if (!rst_i && status_readdata_valid_o) begin
         pulse_cnt++;
      end
   end

   task automatic report_error(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         report_error($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h",
                                name, actual, expected));
      end
   endtask

   // xorshift32 step
   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [`STATUS_AW-1:0] make_addr(input logic [`STAT_AWIDTH-1:0] sel,
                                                       input logic [7:0] idx);
      logic [`STATUS_AW-1:0] addr;
      addr = '0;
      addr[`STATUS_AW-1 -: `STAT_AWIDTH] = sel;   // block select on top bits
      addr[7:0] = idx;
      return addr;
   endfunction

   `include "tb_stats_tasks.svh"

   initial begin
      repeat (TEST_CYCLES * 2) @(posedge clk_status);
      report_error($sformatf("simulation timed out after %0d cycles", TEST_CYCLES * 2));
   end

   initial begin
      rst_i              = 1'b1;
      in_valid_i         = 1'b0;
      in_sop_i           = 1'b0;
      in_eop_i           = 1'b0;
      in_empty_i         = '0;
      fill_level_i       = '0;
      status_addr_i      = '0;
      status_read_i      = 1'b0;
      status_write_i     = 1'b0;
      status_writedata_i = '0;
      rng_state          = 32'd72;
      exp_pkt_cnt        = '0;
      exp_byte_cnt       = '0;
      pulse_cnt          = 0;
      reads_expected     = 0;
      repeat (3) @(posedge clk_status);
      #1 rst_i = 1'b0;

      test_reset_values();
      test_packet_stats();
      test_peak_fill();
      test_control_reg();
      test_freeze_clear();

      idle_cycles(2);
      if (pulse_cnt == reads_expected) begin
         $display("Test passed");
         $finish;
      end else begin
         report_error($sformatf("saw %0d read valid cycles but issued %0d reads",
                                pulse_cnt, reads_expected));
      end
   end

endmodule

// File: verilog.f
+incdir+hdl
+incdir+bench
hdl/stats_pkg.sv
hdl/pkt_counter.sv
hdl/fill_tracker.sv
hdl/stats_regfile.sv
hdl/status_csr.sv
hdl/stats_top.sv
bench/tb_stats_top.sv
